// ==== zint.f ====
+incdir+verilog
verilog/zint_types_pkg.sv
verilog/zint_apb_pkg.sv
verilog/zint_cfg_if.sv
verilog/zint_apb_regs.sv
verilog/zint_line_gen.sv
verilog/zint_dur_timer.sv
verilog/zint_ctrl.sv
verilog/zint_top.sv
verif/zint_clk_gen.sv
verif/zint_checker.sv
verif/zint_tb.sv

// ==== verif/zint_tb.sv ====
`timescale 1ns/1ps
`include "zint_cfg.svh"

module zint_tb;

  typedef enum logic [2:0]
  {
    act_wr,
    act_rd,
    act_stb,
    act_ack,
    act_line,
    act_zpos
  } act_e;

  typedef struct packed
  {
    act_e        act;
    logic [31:0] a0;
    logic [31:0] a1;
    logic        e_int;   // 1 means released and pulled up
    logic [3:0]  e_pend;
    logic [7:0]  e_vec;
    logic [31:0] e_rd;
    logic        e_err;
  } row_t;

  localparam logic [31:0] a_mask = `ZINT_ADDR_MASK;
  localparam logic [31:0] a_line = `ZINT_ADDR_LINE;
  localparam logic [31:0] a_stat = `ZINT_ADDR_STAT;

  // strobe bits of a strobe row
  localparam logic [31:0] stb_frm = 32'h1;
  localparam logic [31:0] stb_dma = 32'h2;
  localparam logic [31:0] stb_wtp = 32'h4;
  localparam logic [31:0] stb_res = 32'h8;

  logic                    clk;
  logic                    int_start_frm;
  logic                    res;
  logic                    zpos;
  logic                    wait_n;
  logic                    vdos;
  logic                    intack;
  logic                    line_strobe;
  logic                    int_start_dma;
  logic                    int_start_wtp;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [`ZINT_APB_AW-1:0] paddr;
  logic [31:0]             pwdata;
  logic [31:0]             prdata;
  logic                    pready;
  logic                    pslverr;
  logic [7:0]              im2vect;
  wire                     int_n;
  logic                    chk_bus;
  logic                    chk_stat;
  logic                    exp_int;
  logic [3:0]              exp_pend;
  logic [7:0]              exp_vec;
  logic [31:0]             exp_rd;
  logic                    exp_err;
  int                      mis_cnt;
  int                      oth_cnt;
  logic [31:0]             lfsr_q;
  row_t                    tbl [0:63];
  int                      n_rows;
  logic                    tbl_ready;

  pullup pu_int (int_n);   // open-drain line

  zint_clk_gen u_clk (.clk(clk));

  zint_top u_dut
  (
    .clk           (clk),
    .int_start_frm (int_start_frm),
    .res           (res),
    .zpos          (zpos),
    .wait_n        (wait_n),
    .vdos          (vdos),
    .intack        (intack),
    .line_strobe   (line_strobe),
    .int_start_dma (int_start_dma),
    .int_start_wtp (int_start_wtp),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .im2vect       (im2vect),
    .int_n         (int_n)
  );

  zint_checker u_chk
  (
    .clk      (clk),
    .chk_bus  (chk_bus),
    .chk_stat (chk_stat),
    .exp_int  (exp_int),
    .exp_pend (exp_pend),
    .exp_vec  (exp_vec),
    .exp_rd   (exp_rd),
    .exp_err  (exp_err),
    .psel     (psel),
    .penable  (penable),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .im2vect  (im2vect),
    .int_n    (int_n),
    .vdos     (vdos),
    .mis_cnt  (mis_cnt),
    .oth_cnt  (oth_cnt)
  );

  // galois form, taps for x^32+x^30+x^26+x^25+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'hA300_0000;
    else
      return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic add_row(input act_e act, input logic [31:0] a0, input logic [31:0] a1,
                         input logic e_int, input logic [3:0] e_pend, input logic [7:0] e_vec,
                         input logic [31:0] e_rd, input logic e_err);
    tbl[n_rows] = {act, a0, a1, e_int, e_pend, e_vec, e_rd, e_err};
    n_rows++;
  endtask

  task automatic next_cycle;
    @(posedge clk);
    #10;   // drive delay
  endtask

  task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                          input logic bus_chk, input logic stat_chk);
    next_cycle;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr[`ZINT_APB_AW-1:0];
    pwdata  = data;
    next_cycle;
    penable  = 1'b1;
    chk_bus  = bus_chk;
    chk_stat = stat_chk;
    next_cycle;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    chk_bus  = 1'b0;
    chk_stat = 1'b0;
  endtask

  task automatic pulse_strobes(input logic [3:0] s, input logic v);
    next_cycle;
    vdos = v;
    next_cycle;
    int_start_frm = s[0];
    int_start_dma = s[1];
    int_start_wtp = s[2];
    res           = s[3];
    next_cycle;
    int_start_frm = 1'b0;
    int_start_dma = 1'b0;
    int_start_wtp = 1'b0;
    res           = 1'b0;
    next_cycle;
    next_cycle;
    vdos = 1'b0;   // frame drop and line gating are done by now
  endtask

  task automatic line_strobes(input int n, input logic v);
    next_cycle;
    vdos = v;
    for (int i = 0; i < n; i++)
    begin
      next_cycle;
      line_strobe = 1'b1;
      next_cycle;
      line_strobe = 1'b0;
    end
    next_cycle;
    vdos = 1'b0;
  endtask

  // w wait cycles from index 2, v vdos cycles after them, neither counts
  task automatic zpos_run(input int n, input int w, input int v);
    for (int i = 0; i < n; i++)
    begin
      next_cycle;
      zpos   = 1'b1;
      wait_n = !((i >= 2) && (i < 2 + w));
      vdos   = (i >= 4 + w) && (i < 4 + w + v);
    end
    next_cycle;
    zpos   = 1'b0;
    wait_n = 1'b1;
    vdos   = 1'b0;
  endtask

  task automatic acknowledge;
    next_cycle;
    intack = 1'b1;
    next_cycle;
    next_cycle;
    intack = 1'b0;
  endtask

  task automatic run_row(input row_t r);
    exp_int  = r.e_int;
    exp_pend = r.e_pend;
    exp_vec  = r.e_vec;
    exp_rd   = r.e_rd;
    exp_err  = r.e_err;
    case (r.act)
      act_wr:   apb_xfer(1'b1, r.a0, r.a1, 1'b1, 1'b0);
      act_rd:   apb_xfer(1'b0, r.a0, 32'h0, 1'b1, 1'b0);
      act_stb:  pulse_strobes(r.a0[3:0], r.a1[0]);
      act_ack:  acknowledge();
      act_line: line_strobes(r.a0, r.a1[0]);
      act_zpos: zpos_run(r.a0, r.a1[7:0], r.a1[15:8]);
      default:  ;
    endcase
    apb_xfer(1'b0, a_stat, 32'h0, 1'b0, 1'b1);   // status check after every row
  endtask

  initial
  begin : main_seq
    logic [31:0] r_mask;
    logic [31:0] r_line;
    logic [31:0] r_cmp;
    logic [31:0] r_w;
    logic [31:0] r_v;

    int_start_frm = 1'b1;
    res           = 1'b0;
    zpos          = 1'b0;
    wait_n        = 1'b1;
    vdos          = 1'b0;
    intack        = 1'b0;
    line_strobe   = 1'b0;
    int_start_dma = 1'b0;
    int_start_wtp = 1'b0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    chk_bus       = 1'b0;
    chk_stat      = 1'b0;
    exp_int       = 1'b1;
    exp_pend      = '0;
    exp_vec       = '0;
    exp_rd        = '0;
    exp_err       = 1'b0;
    lfsr_q        = 32'h8378_fe65;
    n_rows        = 0;
    tbl_ready     = 1'b0;

    take_bits(4, r_mask);
    take_bits(9, r_line);
    take_bits(4, r_cmp);   // small line number keeps the strobe rows short
    take_bits(2, r_w);
    take_bits(2, r_v);
    r_w = r_w + 1;
    r_v = r_v + 1;

    // register access
    add_row(act_wr, a_mask, {28'hfff_ffff, r_mask[3:0]}, 1, 4'h0, 8'hff, 0, 0);
    add_row(act_rd, a_mask, 0, 1, 4'h0, 8'hff, {28'h0, r_mask[3:0]}, 0);
    add_row(act_wr, a_line, {23'h7f_ffff, r_line[8:0]}, 1, 4'h0, 8'hff, 0, 0);
    add_row(act_rd, a_line, 0, 1, 4'h0, 8'hff, {23'h0, r_line[8:0]}, 0);
    add_row(act_rd, 32'hc, 0, 1, 4'h0, 8'hff, 0, 1);
    add_row(act_wr, a_stat, 32'hffff_ffff, 1, 4'h0, 8'hff, 0, 1);
    add_row(act_rd, a_mask, 0, 1, 4'h0, 8'hff, {28'h0, r_mask[3:0]}, 0);
    // frame INT, 31 counted clocks then the 32nd
    add_row(act_wr, a_mask, 32'h1, 1, 4'h0, 8'hff, 0, 0);
    add_row(act_stb, stb_frm, 0, 0, 4'h1, 8'hff, 0, 0);
    add_row(act_zpos, 31 + r_w + r_v, {r_v[7:0], r_w[7:0]}, 0, 4'h1, 8'hff, 0, 0);
    add_row(act_zpos, 1, 0, 1, 4'h0, 8'hff, 0, 0);
    add_row(act_wr, a_mask, 32'h0, 1, 4'h0, 8'hff, 0, 0);
    add_row(act_stb, stb_frm, 0, 1, 4'h0, 8'hff, 0, 0);
    // line match, twice to see the restart
    add_row(act_wr, a_mask, 32'he, 1, 4'h0, 8'hff, 0, 0);
    add_row(act_wr, a_line, r_cmp, 1, 4'h0, 8'hff, 0, 0);
    add_row(act_stb, stb_frm, 0, 1, 4'h0, 8'hff, 0, 0);
    add_row(act_line, r_cmp, 0, 1, 4'h0, 8'hff, 0, 0);
    add_row(act_line, 1, 0, 0, 4'h2, 8'hff, 0, 0);
    add_row(act_ack, 0, 0, 1, 4'h0, 8'hfd, 0, 0);
    add_row(act_stb, stb_frm, 0, 1, 4'h0, 8'hfd, 0, 0);
    add_row(act_line, r_cmp, 0, 1, 4'h0, 8'hfd, 0, 0);
    add_row(act_line, 1, 0, 0, 4'h2, 8'hfd, 0, 0);
    // priority, line then dma then wait-port
    add_row(act_stb, stb_dma | stb_wtp, 0, 0, 4'he, 8'hfd, 0, 0);
    add_row(act_ack, 0, 0, 0, 4'hc, 8'hfd, 0, 0);
    add_row(act_ack, 0, 0, 0, 4'h8, 8'hfb, 0, 0);
    add_row(act_ack, 0, 0, 1, 4'h0, 8'hf9, 0, 0);
    add_row(act_rd, a_stat, 0, 1, 4'h0, 8'hf9, 32'h30, 0);
    // masking and res
    add_row(act_stb, stb_dma | stb_wtp, 0, 0, 4'hc, 8'hf9, 0, 0);
    add_row(act_wr, a_mask, 32'ha, 0, 4'h8, 8'hf9, 0, 0);
    add_row(act_wr, a_mask, 32'he, 0, 4'h8, 8'hf9, 0, 0);
    add_row(act_stb, stb_res, 0, 1, 4'h0, 8'hff, 0, 0);
    add_row(act_rd, a_mask, 0, 1, 4'h0, 8'hff, 0, 0);
    add_row(act_rd, a_line, 0, 1, 4'h0, 8'hff, 0, 0);
    // VDOS, line_cmp is 0 after res
    add_row(act_wr, a_mask, 32'hf, 1, 4'h0, 8'hff, 0, 0);
    add_row(act_stb, stb_frm, 1, 1, 4'h0, 8'hff, 0, 0);
    add_row(act_line, 1, 1, 1, 4'h0, 8'hff, 0, 0);
    add_row(act_stb, stb_dma, 1, 0, 4'h4, 8'hff, 0, 0);
    add_row(act_ack, 0, 0, 1, 4'h0, 8'hfb, 0, 0);
    tbl_ready = 1'b1;

    repeat (4) @(posedge clk);
    #10;
    int_start_frm = 1'b0;
    next_cycle;
    res = 1'b1;
    next_cycle;
    res = 1'b0;

    for (int i = 0; i < n_rows; i++)
      run_row(tbl[i]);

    next_cycle;
    $display("checks done: %0d mismatches, %0d other errors", mis_cnt, oth_cnt);
    if ((mis_cnt == 0) && (oth_cnt == 0))
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  // watchdog, 200 cycles per table row
  initial
  begin
    wait (tbl_ready);
    repeat (n_rows * 200) @(posedge clk);
    $display("timeout: the stimulus table did not finish within %0d cycles", n_rows * 200);
    $display("tests failed");
    $finish;
  end

endmodule

// ==== verif/zint_checker.sv ====
`timescale 1ns/1ps

module zint_checker
(
  input  logic        clk,
  input  logic        chk_bus,    // compare the current APB access
  input  logic        chk_stat,   // compare int_n, pend and vector
  input  logic        exp_int,
  input  logic [3:0]  exp_pend,
  input  logic [7:0]  exp_vec,
  input  logic [31:0] exp_rd,
  input  logic        exp_err,
  input  logic        psel,
  input  logic        penable,
  input  logic [31:0] prdata,
  input  logic        pready,
  input  logic        pslverr,
  input  logic [7:0]  im2vect,
  input  wire         int_n,
  input  logic        vdos,
  output int          mis_cnt,
  output int          oth_cnt
);

  initial
  begin
    mis_cnt = 0;
    oth_cnt = 0;
  end

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
      mis_cnt++;
      $display("mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    end
  endtask

  // falling edge, well clear of the drive delay and the flops
  always @(negedge clk)
  begin
    if (chk_bus)
    begin
      compare("prdata", exp_rd, prdata);
      compare("pslverr", exp_err, pslverr);
      compare("pready", 1'b1, pready);
    end
    if (chk_stat)
    begin
      compare("int_n", exp_int, int_n);
      compare("pend", exp_pend, prdata[3:0]);   // STAT low nibble
      compare("im2vect", exp_vec, im2vect);
    end
    if (vdos && (int_n === 1'b0))
    begin
      oth_cnt++;
      $display("error at %0t: int_n is driven low while vdos is high", $time);
    end
    if (pready && !(psel && penable))
    begin
      oth_cnt++;
      $display("error at %0t: pready is high outside an access phase", $time);
    end
  end

endmodule

// ==== verif/zint_clk_gen.sv ====
`timescale 1ns/1ps

module zint_clk_gen
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever
      #50 clk = ~clk;   // 100 ns period
  end

endmodule

// ==== verilog/zint_top.sv ====
`timescale 1ns/1ps
`include "zint_cfg.svh"

module zint_top
(
  input  logic                   clk,
  input  logic                   int_start_frm,
  input  logic                   res,
  input  logic                   zpos,
  input  logic                   wait_n,
  input  logic                   vdos,
  input  logic                   intack,
  input  logic                   line_strobe,
  input  logic                   int_start_dma,
  input  logic                   int_start_wtp,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`ZINT_APB_AW-1:0] paddr,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic [7:0]             im2vect,
  output wire                    int_n
);

  logic lin_start;
  logic dur_fin;

  zint_cfg_if cfg_if ();

  zint_apb_regs u_regs
  (
    .clk           (clk),
    .int_start_frm (int_start_frm),
    .res           (res),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .cfg           (cfg_if.regs)
  );

  zint_line_gen u_line
  (
    .clk           (clk),
    .int_start_frm (int_start_frm),
    .line_strobe   (line_strobe),
    .cfg           (cfg_if.linegen),
    .lin_start     (lin_start)
  );

  zint_dur_timer u_dur
  (
    .clk           (clk),
    .int_start_frm (int_start_frm),
    .zpos          (zpos),
    .wait_n        (wait_n),
    .vdos          (vdos),
    .dur_fin       (dur_fin)
  );

  zint_ctrl u_ctrl
  (
    .clk           (clk),
    .int_start_frm (int_start_frm),
    .res           (res),
    .lin_start     (lin_start),
    .int_start_dma (int_start_dma),
    .int_start_wtp (int_start_wtp),
    .vdos          (vdos),
    .intack        (intack),
    .dur_fin       (dur_fin),
    .cfg           (cfg_if.ctrl),
    .im2vect       (im2vect),
    .int_n         (int_n)
  );

endmodule

// ==== verilog/zint_ctrl.sv ====
`timescale 1ns/1ps

module zint_ctrl
  import zint_types_pkg::*;
(
  input  logic     clk,
  input  logic     int_start_frm,
  input  logic     res,
  input  logic     lin_start,
  input  logic     int_start_dma,
  input  logic     int_start_wtp,
  input  logic     vdos,
  input  logic     intack,
  input  logic     dur_fin,
  zint_cfg_if.ctrl cfg,
  output vec_t     im2vect,
  output wire      int_n
);

  logic       frm_q;      // frame request
  logic [3:1] oth_q;      // line, dma, wait-port requests
  logic [3:1] start;
  pend_t      pend;
  pend_t      win;        // one-hot winner of an acknowledge
  int_src_e   sel_d;
  int_src_e   sel_q;
  logic       intack_r;
  logic       ack_edge;
  logic       frm_drop;
  logic       int_all;

  // line start is lost in VDOS, dma and wait-port are kept
  assign start = {int_start_wtp, int_start_dma, lin_start && !vdos};

  assign pend = {oth_q, frm_q} & cfg.mask;

  always_comb
  begin
    if (pend[0])
      sel_d = src_frm;
    else if (pend[1])
      sel_d = src_lin;
    else if (pend[2])
      sel_d = src_dma;
    else
      sel_d = src_wtp;
  end

  assign win = (|pend) ? pend_t'(4'b0001 << sel_d) : '0;

  // preset to 1 so a high intack at frame start gives no edge
  always_ff @(posedge clk, posedge int_start_frm)
  begin
    if (int_start_frm)
    begin
      intack_r <= 1'b1;
      ack_edge <= 1'b0;
    end
    else
    begin
      intack_r <= intack;
      ack_edge <= intack && !intack_r;
    end
  end

  // frame start seen while in VDOS
  always_ff @(posedge clk)
    frm_drop <= int_start_frm && vdos;

  always_ff @(posedge clk, posedge int_start_frm)
  begin
    if (int_start_frm)
      frm_q <= 1'b1;
    else if (res || !cfg.mask[0] || frm_drop)
      frm_q <= 1'b0;
    else if (dur_fin || (ack_edge && win[0]))
      frm_q <= 1'b0;   // INT length over or acked
  end

  always_ff @(posedge clk)
  begin
    for (int i = 1; i < 4; i++)
    begin
      if (res || !cfg.mask[i])
        oth_q[i] <= 1'b0;
      else if (start[i])
        oth_q[i] <= 1'b1;   // start wins over ack
      else if (ack_edge && win[i])
        oth_q[i] <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (res)
      sel_q <= src_frm;
    else if (ack_edge && (|pend))
      sel_q <= sel_d;
  end

  always_comb
  begin
    unique case (sel_q)
      src_frm: im2vect = vec_t'(8'hFF);
      src_lin: im2vect = vec_t'(8'hFD);
      src_dma: im2vect = vec_t'(8'hFB);
      src_wtp: im2vect = vec_t'(8'hF9);
    endcase
  end

  assign int_all = (|pend) && !vdos;   // VDOS blocks the output only
  assign int_n   = int_all ? 1'b0 : 1'bz;

  assign cfg.pend    = pend;
  assign cfg.int_sel = sel_q;

  a_vdos_blk: assert property (@(posedge clk) vdos |-> (int_n !== 1'b0))
    else $error("ctrl: int_n low during VDOS");

endmodule

// ==== verilog/zint_dur_timer.sv ====
`timescale 1ns/1ps
`include "zint_cfg.svh"

module zint_dur_timer
  import zint_types_pkg::*;
(
  input  logic clk,
  input  logic int_start_frm,
  input  logic zpos,
  input  logic wait_n,
  input  logic vdos,
  output logic dur_fin
);

  localparam dur_t dur_end = dur_t'(1) << (`ZINT_DUR_W - 1);   // 32 clocks

  dur_t cnt_q;
  logic wait_r;
  logic fin_r;
  logic done;
  logic cnt_en;

  always_ff @(posedge clk)
    wait_r <= !wait_n;   // wait resync

  assign done   = cnt_q[`ZINT_DUR_W-1];
  assign cnt_en = zpos && !wait_r && !vdos && !done;

  // held at zero during frame start, then counts enabled Z80 clocks
  always_ff @(posedge clk, posedge int_start_frm)
  begin
    if (int_start_frm)
    begin
      cnt_q <= '0;
      fin_r <= 1'b0;
    end
    else
    begin
      if (cnt_en)
        cnt_q <= cnt_q + dur_t'(1);
      fin_r <= done;
    end
  end

  assign dur_fin = done && !fin_r;   // once per frame

  a_cnt_max: assert property (@(posedge clk) disable iff (int_start_frm)
    cnt_q <= dur_end)
    else $error("dur_timer: counter passed 32");

endmodule

// ==== verilog/zint_line_gen.sv ====
`timescale 1ns/1ps

module zint_line_gen
  import zint_types_pkg::*;
(
  input  logic        clk,
  input  logic        int_start_frm,
  input  logic        line_strobe,
  zint_cfg_if.linegen cfg,
  output logic        lin_start
);

  line_t line_q;   // current raster line
  logic  hit;

  assign hit = line_strobe && (line_q == cfg.line_cmp);

  // first strobe after frame start is line 0
  always_ff @(posedge clk, posedge int_start_frm)
  begin
    if (int_start_frm)
    begin
      line_q    <= '0;
      lin_start <= 1'b0;
    end
    else
    begin
      if (line_strobe)
        line_q <= line_q + line_t'(1);
      lin_start <= hit;   // one pulse per match
    end
  end

  // counter moves on after a match, so no second hit follows
  a_lin_pulse: assert property (@(posedge clk) disable iff (int_start_frm)
    lin_start |=> !lin_start)
    else $error("line_gen: lin_start longer than one cycle");

endmodule

// ==== verilog/zint_apb_regs.sv ====
`timescale 1ns/1ps
`include "zint_cfg.svh"

module zint_apb_regs
  import zint_types_pkg::*;
  import zint_apb_pkg::*;
(
  input  logic     clk,
  input  logic     int_start_frm,
  input  logic     res,
  input  logic     psel,
  input  logic     penable,
  input  logic     pwrite,
  input  paddr_t   paddr,
  input  pdata_t   pwdata,
  output pdata_t   prdata,
  output logic     pready,
  output logic     pslverr,
  zint_cfg_if.regs cfg
);

  apb_phase_e phase_now;
  apb_phase_e phase_q;   // phase seen in the previous cycle
  reg_addr_e  ra;
  logic       addr_ok;
  logic       acc;
  logic       wr_en;
  mask_t      mask_q;
  line_t      line_q;

  // bus phase of the current cycle
  always_comb
  begin
    if (!psel)
      phase_now = ph_idle;
    else if (!penable)
      phase_now = ph_setup;
    else
      phase_now = ph_access;
  end

  always_ff @(posedge clk, posedge int_start_frm)
  begin
    if (int_start_frm)
      phase_q <= ph_idle;
    else if (res)
      phase_q <= ph_idle;
    else
      phase_q <= phase_now;
  end

  // access only counts when it follows a setup cycle
  assign acc = (phase_now == ph_access) && (phase_q == ph_setup);

  assign ra      = reg_addr_e'(paddr);
  assign addr_ok = (ra == ra_mask) || (ra == ra_line) || (ra == ra_stat);
  assign wr_en   = acc && pwrite && addr_ok && (ra != ra_stat);

  assign pready  = acc;   // zero wait states
  assign pslverr = acc && (!addr_ok || (pwrite && (ra == ra_stat)));

  always_comb
  begin
    prdata = '0;
    if (acc && !pwrite)
    begin
      case (ra)
        ra_mask: prdata = pdata_t'(mask_q);
        ra_line: prdata = pdata_t'(line_q);
        ra_stat: prdata = pdata_t'({cfg.int_sel, cfg.pend});
        default: prdata = '0;
      endcase
    end
  end

  // config survives frame start, only res clears it
  always_ff @(posedge clk)
  begin
    if (res)
    begin
      mask_q <= '0;
      line_q <= '0;
    end
    else if (wr_en)
    begin
      if (ra == ra_mask)
        mask_q <= pwdata[$bits(mask_t)-1:0];
      if (ra == ra_line)
        line_q <= pwdata[`ZINT_LINE_W-1:0];
    end
  end

  assign cfg.mask     = mask_q;
  assign cfg.line_cmp = line_q;

  a_penable_psel: assert property (@(posedge clk) disable iff (int_start_frm)
    penable |-> psel)
    else $error("apb: penable without psel");

endmodule

// ==== verilog/zint_cfg_if.sv ====
`timescale 1ns/1ps

interface zint_cfg_if
  import zint_types_pkg::*;
();

  mask_t    mask;       // source enables
  line_t    line_cmp;   // line INT compare value
  pend_t    pend;       // masked pending flags
  int_src_e int_sel;    // last acknowledged source

  modport regs
  (
    output mask,
    output line_cmp,
    input  pend,
    input  int_sel
  );

  modport linegen
  (
    input line_cmp
  );

  modport ctrl
  (
    input  mask,
    output pend,
    output int_sel
  );

endinterface

// ==== verilog/zint_apb_pkg.sv ====
`include "zint_cfg.svh"

package zint_apb_pkg;

  typedef logic [`ZINT_APB_AW-1:0] paddr_t;
  typedef logic [31:0] pdata_t;

  typedef enum logic [`ZINT_APB_AW-1:0]
  {
    ra_mask = `ZINT_ADDR_MASK,
    ra_line = `ZINT_ADDR_LINE,
    ra_stat = `ZINT_ADDR_STAT    // read only
  } reg_addr_e;

  typedef enum logic [1:0]
  {
    ph_idle,
    ph_setup,
    ph_access
  } apb_phase_e;

endpackage

// ==== verilog/zint_types_pkg.sv ====
`include "zint_cfg.svh"

package zint_types_pkg;

  // IM2 vector placed on the data bus
  typedef logic [7:0] vec_t;

  // bit order: frame, line, dma, wait-port
  typedef logic [3:0] mask_t;

  typedef logic [`ZINT_LINE_W-1:0] line_t;

  // same bit order as mask_t
  typedef logic [3:0] pend_t;

  typedef logic [`ZINT_DUR_W-1:0] dur_t;   // frame INT length count

  // declaration order is the priority order
  typedef enum logic [1:0]
  {
    src_frm,
    src_lin,
    src_dma,
    src_wtp
  } int_src_e;

endpackage

// ==== verilog/zint_cfg.svh ====
`ifndef ZINT_CFG_SVH
`define ZINT_CFG_SVH

// raster line number width
`define ZINT_LINE_W 9

// frame INT length counter, msb set after 32 counts
`define ZINT_DUR_W 6

// APB address width and register byte offsets
`define ZINT_APB_AW 4
`define ZINT_ADDR_MASK 4'h0
`define ZINT_ADDR_LINE 4'h4
`define ZINT_ADDR_STAT 4'h8

`endif
